/* src/firmat_pkg.sv */
package firmat_pkg;

  // word width for samples, taps, matrix elements and results
  localparam int DATA_W = 32;

  // one multiplier lane per fir tap
  localparam int NUM_LANES = 11;

  localparam int FIR_SAMPLES = 64;

  localparam int MAT_DIM = 4;
  // a, then b transposed
  localparam int MAT_WORDS = 2 * MAT_DIM * MAT_DIM;

  typedef logic [DATA_W-1:0] word_t;
  typedef word_t [NUM_LANES-1:0] lanes_t;
  typedef logic [3:0] tap_idx_t;

  typedef enum logic [1:0] {
    FIR_IDLE,
    FIR_TAPS,
    FIR_SAMPLE,
    FIR_ISSUE
  } fir_state_t;

  typedef enum logic [1:0] {
    MAT_IDLE,
    MAT_LOAD,
    MAT_ISSUE
  } mat_state_t;

endpackage

/* src/dot_product_unit.sv */
module dot_product_unit (
  input  logic               clk,
  input  logic               rst,
  input  logic               op_valid,
  input  logic               op_last,
  input  firmat_pkg::lanes_t op_a,
  input  firmat_pkg::lanes_t op_b,
  output logic               op_ready,
  output logic               res_valid,
  output logic               res_last,
  input  logic               res_ready,
  output firmat_pkg::word_t  res_data
);
  import firmat_pkg::*;

  word_t sum;
  logic  op_fire;

  // free slot, or the held result leaves this cycle
  assign op_ready = !res_valid || res_ready;
  assign op_fire  = op_valid && op_ready;

  // products and sum wrap at DATA_W bits
  always_comb begin
    sum = '0;
    for (int k = 0; k < NUM_LANES; k++) begin
      sum = sum + op_a[k] * op_b[k];
    end
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      res_valid <= 1'b0;
    end else if (op_fire) begin
      res_valid <= 1'b1;
    end else if (res_ready) begin
      res_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (op_fire) begin
      res_data <= sum;
      res_last <= op_last;
    end
  end

endmodule

/* src/fir_engine.sv */
module fir_engine (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               s_valid,
  input  firmat_pkg::word_t  s_data,
  output logic               s_ready,
  output logic               op_valid,
  output logic               op_last,
  input  logic               op_ready,
  output firmat_pkg::lanes_t op_a,
  output firmat_pkg::lanes_t op_b
);
  import firmat_pkg::*;

  fir_state_t state;
  fir_state_t state_next;

  tap_idx_t                       tap_cnt;
  logic [$clog2(FIR_SAMPLES)-1:0] sample_cnt;

  lanes_t taps;
  // slot k holds the sample k steps back
  lanes_t dline;

  logic s_fire;
  logic op_fire;
  logic run_start;
  logic last_tap;
  logic last_sample;

  assign s_ready   = (state == FIR_TAPS) || (state == FIR_SAMPLE);
  assign s_fire    = s_valid && s_ready;
  assign op_valid  = (state == FIR_ISSUE);
  assign op_fire   = op_valid && op_ready;
  assign run_start = start && (state == FIR_IDLE);

  assign last_tap    = (int'(tap_cnt) == NUM_LANES - 1);
  assign last_sample = (int'(sample_cnt) == FIR_SAMPLES - 1);

  assign op_last = op_valid && last_sample;
  assign op_a    = taps;
  assign op_b    = dline;

  always_comb begin
    state_next = state;
    case (state)
      FIR_IDLE: begin
        if (start) begin
          state_next = FIR_TAPS;
        end
      end
      FIR_TAPS: begin
        if (s_fire && last_tap) begin
          state_next = FIR_SAMPLE;
        end
      end
      FIR_SAMPLE: begin
        // one op per sample, so stop taking input until it is issued
        if (s_fire) begin
          state_next = FIR_ISSUE;
        end
      end
      FIR_ISSUE: begin
        if (op_fire) begin
          state_next = last_sample ? FIR_IDLE : FIR_SAMPLE;
        end
      end
      default: begin
        state_next = FIR_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state      <= FIR_IDLE;
      tap_cnt    <= '0;
      sample_cnt <= '0;
    end else begin
      state <= state_next;
      if (run_start) begin
        tap_cnt    <= '0;
        sample_cnt <= '0;
      end else begin
        if (s_fire && (state == FIR_TAPS)) begin
          tap_cnt <= tap_cnt + 1'b1;
        end
        // counts issued outputs
        if (op_fire) begin
          sample_cnt <= sample_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire && (state == FIR_TAPS)) begin
      taps[tap_cnt] <= s_data;
    end
  end

  // delay line starts from zero on every run
  always_ff @(posedge clk) begin
    if (run_start) begin
      dline <= '0;
    end else if (s_fire && (state == FIR_SAMPLE)) begin
      dline <= {dline[NUM_LANES-2:0], s_data};
    end
  end

endmodule

/* src/matmul_engine.sv */
module matmul_engine (
  input  logic               clk,
  input  logic               rst,
  input  logic               start,
  input  logic               s_valid,
  input  firmat_pkg::word_t  s_data,
  output logic               s_ready,
  output logic               op_valid,
  output logic               op_last,
  input  logic               op_ready,
  output firmat_pkg::lanes_t op_a,
  output firmat_pkg::lanes_t op_b
);
  import firmat_pkg::*;

  mat_state_t state;
  mat_state_t state_next;

  logic [$clog2(MAT_WORDS)-1:0]         load_cnt;
  logic [$clog2(MAT_DIM * MAT_DIM)-1:0] issue_cnt;

  // words 0..15 are a row-major, 16..31 are b transposed
  word_t mat_mem [MAT_WORDS];

  int row_base;
  int col_base;

  logic s_fire;
  logic op_fire;
  logic last_word;
  logic last_issue;

  assign s_ready  = (state == MAT_LOAD);
  assign s_fire   = s_valid && s_ready;
  assign op_valid = (state == MAT_ISSUE);
  assign op_fire  = op_valid && op_ready;

  assign last_word  = (int'(load_cnt) == MAT_WORDS - 1);
  assign last_issue = (int'(issue_cnt) == MAT_DIM * MAT_DIM - 1);
  assign op_last    = op_valid && last_issue;

  always_comb begin
    state_next = state;
    case (state)
      MAT_IDLE: begin
        if (start) begin
          state_next = MAT_LOAD;
        end
      end
      MAT_LOAD: begin
        if (s_fire && last_word) begin
          state_next = MAT_ISSUE;
        end
      end
      MAT_ISSUE: begin
        if (op_fire && last_issue) begin
          state_next = MAT_IDLE;
        end
      end
      default: begin
        state_next = MAT_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      state     <= MAT_IDLE;
      load_cnt  <= '0;
      issue_cnt <= '0;
    end else begin
      state <= state_next;
      if (start && (state == MAT_IDLE)) begin
        load_cnt  <= '0;
        issue_cnt <= '0;
      end else begin
        if (s_fire) begin
          load_cnt <= load_cnt + 1'b1;
        end
        if (op_fire) begin
          issue_cnt <= issue_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (s_fire) begin
      mat_mem[load_cnt] <= s_data;
    end
  end

  // c[i][j] in row-major order: i from the upper bits, j from the lower
  always_comb begin
    row_base = (int'(issue_cnt) / MAT_DIM) * MAT_DIM;
    col_base = MAT_DIM * MAT_DIM + (int'(issue_cnt) % MAT_DIM) * MAT_DIM;
    op_a     = '0;
    op_b     = '0;
    for (int k = 0; k < MAT_DIM; k++) begin
      op_a[k] = mat_mem[row_base + k];
      op_b[k] = mat_mem[col_base + k];
    end
  end

endmodule

/* src/firmat_top.sv */
module firmat_top (
  input  logic              clk,
  input  logic              rst,
  input  logic              fir_start,
  input  logic              fir_valid,
  input  logic              mat_start,
  input  logic              mat_valid,
  input  logic              res_ready,
  input  firmat_pkg::word_t fir_data,
  input  firmat_pkg::word_t mat_data,
  output logic              fir_ready,
  output logic              mat_ready,
  output logic              res_valid,
  output logic              fir_done,
  output logic              mat_done,
  output firmat_pkg::word_t res_data
);
  import firmat_pkg::*;

  // active job, both low means none
  logic fir_active;
  logic mat_active;

  logic fir_go;
  logic mat_go;
  logic run_end;

  logic   fir_op_valid;
  logic   fir_op_last;
  logic   fir_op_ready;
  lanes_t fir_op_a;
  lanes_t fir_op_b;

  logic   mat_op_valid;
  logic   mat_op_last;
  logic   mat_op_ready;
  lanes_t mat_op_a;
  lanes_t mat_op_b;

  logic   unit_op_valid;
  logic   unit_op_last;
  logic   unit_op_ready;
  lanes_t unit_op_a;
  lanes_t unit_op_b;
  logic   res_last;

  // fir wins a tie, starts during a run are dropped
  assign fir_go  = fir_start && !fir_active && !mat_active;
  assign mat_go  = mat_start && !fir_start && !fir_active && !mat_active;
  assign run_end = res_valid && res_ready && res_last;

  assign fir_done = run_end && fir_active;
  assign mat_done = run_end && mat_active;

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      fir_active <= 1'b0;
      mat_active <= 1'b0;
    end else if (run_end) begin
      fir_active <= 1'b0;
      mat_active <= 1'b0;
    end else begin
      if (fir_go) begin
        fir_active <= 1'b1;
      end
      if (mat_go) begin
        mat_active <= 1'b1;
      end
    end
  end

  // operand select for the shared unit
  always_comb begin
    unit_op_valid = 1'b0;
    unit_op_last  = 1'b0;
    unit_op_a     = fir_op_a;
    unit_op_b     = fir_op_b;
    if (fir_active) begin
      unit_op_valid = fir_op_valid;
      unit_op_last  = fir_op_last;
    end else if (mat_active) begin
      unit_op_valid = mat_op_valid;
      unit_op_last  = mat_op_last;
      unit_op_a     = mat_op_a;
      unit_op_b     = mat_op_b;
    end
  end

  assign fir_op_ready = unit_op_ready && fir_active;
  assign mat_op_ready = unit_op_ready && mat_active;

  fir_engine u_fir_engine (
    .clk      (clk),
    .rst      (rst),
    .start    (fir_go),
    .s_valid  (fir_valid),
    .s_data   (fir_data),
    .s_ready  (fir_ready),
    .op_valid (fir_op_valid),
    .op_last  (fir_op_last),
    .op_ready (fir_op_ready),
    .op_a     (fir_op_a),
    .op_b     (fir_op_b)
  );

  matmul_engine u_matmul_engine (
    .clk      (clk),
    .rst      (rst),
    .start    (mat_go),
    .s_valid  (mat_valid),
    .s_data   (mat_data),
    .s_ready  (mat_ready),
    .op_valid (mat_op_valid),
    .op_last  (mat_op_last),
    .op_ready (mat_op_ready),
    .op_a     (mat_op_a),
    .op_b     (mat_op_b)
  );

  dot_product_unit u_dot_product_unit (
    .clk       (clk),
    .rst       (rst),
    .op_valid  (unit_op_valid),
    .op_last   (unit_op_last),
    .op_a      (unit_op_a),
    .op_b      (unit_op_b),
    .op_ready  (unit_op_ready),
    .res_valid (res_valid),
    .res_last  (res_last),
    .res_ready (res_ready),
    .res_data  (res_data)
  );

endmodule

/* testbench/tb_firmat_checks.svh */
task automatic check_word(input string name, input word_t exp, input word_t act);
  if (act !== exp) begin
    $display("Fail %s expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    $display("Fail %s expected %h actual %h", name, exp, act);
    abort_run();
  end
endtask

task automatic pulse_start(input logic is_mat, input logic taken);
  @(negedge clk);
  fir_start = !is_mat;
  mat_start = is_mat;
  @(negedge clk);
  fir_start = 1'b0;
  mat_start = 1'b0;
  #1;
  // ready rises one cycle after a start is taken
  check_bit(is_mat ? "mat_ready" : "fir_ready", taken, is_mat ? mat_ready : fir_ready);
endtask

task automatic send_stream(input logic is_mat);
  foreach (in_q[i]) begin
    @(negedge clk);
    fir_valid = !is_mat;
    mat_valid = is_mat;
    fir_data  = in_q[i];
    mat_data  = in_q[i];
    #1;
    // word held until the engine takes it
    while (!(is_mat ? mat_ready : fir_ready)) begin
      @(negedge clk);
      #1;
    end
  end
  @(negedge clk);
  fir_valid = 1'b0;
  mat_valid = 1'b0;
endtask

task automatic collect_results(input logic is_mat, input logic stall);
  int   idx;
  logic xfer;
  logic last;
  idx = 0;
  while (idx < exp_q.size()) begin
    @(negedge clk);
    res_ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
    #1;
    xfer = res_valid && res_ready;
    last = xfer && (idx == exp_q.size() - 1);
    check_bit("fir_done", last && !is_mat, fir_done);
    check_bit("mat_done", last && is_mat, mat_done);
    if (xfer) begin
      check_word("res_data", exp_q[idx], res_data);
      idx++;
    end
  end
endtask

function automatic void random_words(input int count);
  in_q.delete();
  repeat (count) in_q.push_back($random(seed));
endfunction

// taps first in in_q, then the samples
function automatic void fir_model();
  word_t acc;
  exp_q.delete();
  for (int n = 0; n < FIR_SAMPLES; n++) begin
    acc = '0;
    for (int k = 0; k <= n && k < NUM_LANES; k++)
      acc = acc + in_q[k] * in_q[NUM_LANES + n - k];
    exp_q.push_back(acc);
  end
endfunction

function automatic void mat_model();
  word_t acc;
  exp_q.delete();
  for (int i = 0; i < MAT_DIM; i++) begin
    for (int j = 0; j < MAT_DIM; j++) begin
      acc = '0;
      // column j of b is row j of the transposed half
      for (int k = 0; k < MAT_DIM; k++)
        acc = acc + in_q[i * MAT_DIM + k] * in_q[(MAT_DIM + j) * MAT_DIM + k];
      exp_q.push_back(acc);
    end
  end
endfunction

/* testbench/tb_firmat.sv */
module tb_firmat;
  timeunit 1ns;
  timeprecision 1ps;
  import firmat_pkg::*;

  localparam int CLK_PERIOD = 4;
  // three fir runs and two matmul runs, input words plus results
  localparam int TOTAL_WORDS = 3 * (NUM_LANES + 2 * FIR_SAMPLES)
                             + 2 * (MAT_WORDS + MAT_DIM * MAT_DIM);

  logic  clk = 1'b0;
  logic  rst = 1'b1;
  logic  fir_start = 1'b0;
  logic  fir_valid = 1'b0;
  word_t fir_data = '0;
  logic  mat_start = 1'b0;
  logic  mat_valid = 1'b0;
  word_t mat_data = '0;
  logic  res_ready = 1'b0;
  logic  fir_ready, mat_ready, res_valid, fir_done, mat_done;
  word_t res_data;

  integer seed = 48065;
  word_t  in_q[$];
  word_t  exp_q[$];

  firmat_top UUT (.*);

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run();
    $display("SIMULATION FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  `include "tb_firmat_checks.svh"

  task automatic run_job(input logic is_mat, input logic stall);
    pulse_start(is_mat, 1'b1);
    fork
      send_stream(is_mat);
      collect_results(is_mat, stall);
    join
    // no stray results and neither engine loading afterwards
    repeat (4) begin
      @(negedge clk);
      #1;
      check_bit("res_valid", 1'b0, res_valid);
      check_bit("fir_ready", 1'b0, fir_ready);
      check_bit("mat_ready", 1'b0, mat_ready);
    end
  endtask

  task automatic test_fir_impulse();
    in_q.delete();
    exp_q.delete();
    for (int k = 1; k <= NUM_LANES; k++) begin
      in_q.push_back(k);
      exp_q.push_back(k);
    end
    // a single impulse reads the taps back out
    in_q.push_back(1);
    repeat (FIR_SAMPLES - 1) in_q.push_back('0);
    repeat (FIR_SAMPLES - NUM_LANES) exp_q.push_back('0);
    run_job(1'b0, 1'b0);
  endtask

  task automatic test_fir_random();
    random_words(NUM_LANES + FIR_SAMPLES);
    fir_model();
    run_job(1'b0, 1'b1);
  endtask

  task automatic test_matmul();
    random_words(MAT_WORDS);
    mat_model();
    run_job(1'b1, 1'b0);
  endtask

  task automatic test_start_during_run();
    random_words(NUM_LANES + FIR_SAMPLES);
    fir_model();
    fork
      run_job(1'b0, 1'b0);
      begin
        repeat (30) @(negedge clk);
        pulse_start(1'b1, 1'b0);
        repeat (20) begin
          @(negedge clk);
          #1;
          check_bit("mat_ready", 1'b0, mat_ready);
        end
      end
    join
    random_words(MAT_WORDS);
    mat_model();
    run_job(1'b1, 1'b1);
  endtask

  initial begin
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    #1;
    // reset state
    check_bit("fir_ready", 1'b0, fir_ready);
    check_bit("mat_ready", 1'b0, mat_ready);
    check_bit("res_valid", 1'b0, res_valid);
    check_bit("fir_done", 1'b0, fir_done);
    check_bit("mat_done", 1'b0, mat_done);
    test_fir_impulse();
    test_fir_random();
    test_matmul();
    test_start_during_run();
    $display("SIMULATION PASSED");
    $finish;
  end

  // about 50 clock periods per word moved
  initial begin
    #(CLK_PERIOD * 50 * TOTAL_WORDS);
    $display("Timeout, the tests did not finish within %0d clock periods", 50 * TOTAL_WORDS);
    abort_run();
  end

endmodule

/* firmat.f */
+incdir+testbench
src/firmat_pkg.sv
src/dot_product_unit.sv
src/fir_engine.sv
src/matmul_engine.sv
src/firmat_top.sv
testbench/tb_firmat.sv

/* Bender.yml */
package:
  name: firmat

sources:
  - src/firmat_pkg.sv
  - src/dot_product_unit.sv
  - src/fir_engine.sv
  - src/matmul_engine.sv
  - src/firmat_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_firmat.sv
